/* filelist.f */
verilog/mm_pkg.sv
verilog/mm_reg_decode.sv
verilog/mm_ctrl.sv
verilog/mm_mac_engine.sv
verilog/mm_z_buffer.sv
verilog/mm_top.sv
verification/mm_tb_clkgen.sv
verification/mm_ctrl_asserts.sv
verification/mm_tb.sv

/* verification/mm_tb.sv */
// Testbench for the matrix-vector multiply accelerator.
// Loads W and X over AXI4-Lite, runs jobs, and compares every Z word
// with a reference model. Responses are held back by random B and R
// ready delays, and irq pulses are counted against started jobs.

`timescale 1ns/10ps
`default_nettype none

module mm_tb;

  localparam int unsigned DIM         = 4;
  localparam int unsigned MAX_POLLS   = 10;
  localparam int unsigned NUM_RAND    = 4;
  localparam int unsigned NUM_JOBS    = NUM_RAND + 5;
  // Upper bound of AXI transactions for one job, loads included
  localparam int unsigned TXN_PER_JOB = DIM * DIM + DIM + 1 + MAX_POLLS + DIM;
  localparam int unsigned TXN_TOTAL   = NUM_JOBS * TXN_PER_JOB + 32;

  logic              clk;
  logic              rst_n;
  logic              awvalid;
  mm_pkg::axi_addr_t awaddr;
  logic              wvalid;
  mm_pkg::axi_data_t wdata;
  logic              bready;
  logic              arvalid;
  mm_pkg::axi_addr_t araddr;
  logic              rready;
  logic              awready;
  logic              wready;
  logic              bvalid;
  logic [1:0]        bresp;
  logic              arready;
  logic              rvalid;
  mm_pkg::axi_data_t rdata;
  logic [1:0]        rresp;
  logic              irq;

  // Testbench copies of the operands and expected results
  mm_pkg::elem_t w_m [DIM][DIM];
  mm_pkg::elem_t x_m [DIM];
  mm_pkg::acc_t  z_ref [DIM];

  int unsigned bp_max;
  int unsigned irq_count = 0;
  int unsigned jobs_started;

  mm_tb_clkgen #(
    .PERIOD_NS    (20),
    .RESET_CYCLES (3)
  ) i_clkgen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  mm_top #(
    .DIM (DIM)
  ) i_dut (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .awvalid_i (awvalid),
    .awaddr_i  (awaddr),
    .wvalid_i  (wvalid),
    .wdata_i   (wdata),
    .bready_i  (bready),
    .arvalid_i (arvalid),
    .araddr_i  (araddr),
    .rready_i  (rready),
    .awready_o (awready),
    .wready_o  (wready),
    .bvalid_o  (bvalid),
    .bresp_o   (bresp),
    .arready_o (arready),
    .rvalid_o  (rvalid),
    .rdata_o   (rdata),
    .rresp_o   (rresp),
    .irq_o     (irq)
  );

  // Z[i] = prev + sum of signed W[i][j] * X[j], wrapping at 32 bits
  function automatic mm_pkg::acc_t ref_matvec(input int i, input logic acc);
    mm_pkg::acc_t sum;
    int           prod;
    sum = acc ? z_ref[i] : '0;
    for (int j = 0; j < DIM; j++) begin
      prod = int'(w_m[i][j]) * int'(x_m[j]);
      sum  = sum + mm_pkg::acc_t'(prod);
    end
    return sum;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("ERROR: %s is 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic axi_write(input mm_pkg::axi_addr_t addr, input mm_pkg::axi_data_t data,
                           output logic [1:0] resp);
    int unsigned delay;
    delay   = $urandom_range(bp_max, 0);
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    @(negedge clk);
    while (!awready) begin
      @(negedge clk);
    end
    check_eq("wready_o", wready, 1'b1);
    @(posedge clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge clk);
    if (!bvalid) begin
      fail_now("Write response did not arrive in the cycle after the handshake");
    end
    resp = bresp;
    // Response must hold while BREADY is low
    repeat (delay) begin
      @(negedge clk);
      check_eq("bvalid_o", bvalid, 1'b1);
      check_eq("bresp_o", bresp, resp);
    end
    @(posedge clk);
    #1;
    bready = 1'b1;
    @(negedge clk);
    check_eq("bvalid_o", bvalid, 1'b1);
    check_eq("bresp_o", bresp, resp);
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axi_read(input mm_pkg::axi_addr_t addr, output mm_pkg::axi_data_t data,
                          output logic [1:0] resp);
    int unsigned delay;
    delay   = $urandom_range(bp_max, 0);
    arvalid = 1'b1;
    araddr  = addr;
    @(negedge clk);
    while (!arready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    @(negedge clk);
    if (!rvalid) begin
      fail_now("Read data did not arrive in the cycle after the handshake");
    end
    data = rdata;
    resp = rresp;
    repeat (delay) begin
      @(negedge clk);
      check_eq("rvalid_o", rvalid, 1'b1);
      check_eq("rdata_o", rdata, data);
      check_eq("rresp_o", rresp, resp);
    end
    @(posedge clk);
    #1;
    rready = 1'b1;
    @(negedge clk);
    check_eq("rdata_o", rdata, data);
    check_eq("rresp_o", rresp, resp);
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  task automatic write_expect(input mm_pkg::axi_addr_t addr, input mm_pkg::axi_data_t data,
                              input logic [1:0] exp_resp);
    logic [1:0] resp;
    axi_write(addr, data, resp);
    check_eq($sformatf("bresp_o @0x%03h", addr), resp, exp_resp);
  endtask

  task automatic read_expect(input string name, input mm_pkg::axi_addr_t addr,
                             input mm_pkg::axi_data_t exp_data, input logic [1:0] exp_resp);
    mm_pkg::axi_data_t data;
    logic [1:0]        resp;
    axi_read(addr, data, resp);
    check_eq({"rresp_o ", name}, resp, exp_resp);
    check_eq({"rdata_o ", name}, data, exp_data);
  endtask

  // Directed fill drives the most negative products for wraparound
  task automatic load_operands(input logic directed);
    for (int i = 0; i < DIM; i++) begin
      for (int j = 0; j < DIM; j++) begin
        w_m[i][j] = directed ? mm_pkg::elem_t'(16'h8000) : mm_pkg::elem_t'($urandom());
        write_expect(mm_pkg::W_BASE + 4 * (i * DIM + j), {16'h0, w_m[i][j]},
                     mm_pkg::resp_okay);
      end
    end
    for (int j = 0; j < DIM; j++) begin
      if (directed) begin
        x_m[j] = (j == DIM - 1) ? mm_pkg::elem_t'(16'h7fff) : mm_pkg::elem_t'(16'h8000);
      end else begin
        x_m[j] = mm_pkg::elem_t'($urandom());
      end
      write_expect(mm_pkg::X_BASE + 4 * j, {16'h0, x_m[j]}, mm_pkg::resp_okay);
    end
  endtask

  task automatic wait_done();
    mm_pkg::axi_data_t data;
    logic [1:0]        resp;
    int unsigned       polls;
    polls = 0;
    data  = '0;
    while (data[1:0] != 2'b10) begin
      if (polls == MAX_POLLS) begin
        fail_now("Job did not finish within the expected number of STATUS polls");
      end
      axi_read(mm_pkg::REG_STATUS, data, resp);
      check_eq("rresp_o STATUS", resp, mm_pkg::resp_okay);
      polls++;
    end
  endtask

  task automatic check_z();
    for (int i = 0; i < DIM; i++) begin
      read_expect($sformatf("Z[%0d]", i), mm_pkg::Z_BASE + 4 * i, z_ref[i], mm_pkg::resp_okay);
    end
  endtask

  task automatic run_job(input logic acc);
    write_expect(mm_pkg::REG_CTRL, {30'b0, acc, 1'b1}, mm_pkg::resp_okay);
    jobs_started++;
    wait_done();
    for (int i = 0; i < DIM; i++) begin
      z_ref[i] = ref_matvec(i, acc);
    end
    check_z();
  endtask

  always @(negedge clk) begin
    if (rst_n && irq) begin
      irq_count++;
    end
  end

  // A controller assertion failure ends the run at once
  always @(negedge clk) begin
    if (i_dut.i_ctrl.i_ctrl_asserts.fail_cnt != 0) begin
      fail_now("A controller assertion failed");
    end
  end

  initial begin : watchdog
    repeat (TXN_TOTAL * 200) @(posedge clk);
    $display("Watchdog expired: tests did not finish within %0d cycles", TXN_TOTAL * 200);
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  initial begin : main
    int unsigned irq_before;
    void'($urandom(40));
    awvalid      = 1'b0;
    awaddr       = '0;
    wvalid       = 1'b0;
    wdata        = '0;
    bready       = 1'b0;
    arvalid      = 1'b0;
    araddr       = '0;
    rready       = 1'b0;
    bp_max       = 3;
    jobs_started = 0;
    for (int i = 0; i < DIM; i++) begin
      z_ref[i] = '0;
    end
    @(posedge rst_n);
    @(posedge clk);
    #1;

    // Reset state, unmapped and read-only accesses
    check_eq("arready_o", arready, 1'b1);
    check_eq("bvalid_o", bvalid, 1'b0);
    check_eq("rvalid_o", rvalid, 1'b0);
    read_expect("STATUS", mm_pkg::REG_STATUS, 32'h0, mm_pkg::resp_okay);
    check_z();
    read_expect("unmapped", 12'h050, 32'h0, mm_pkg::resp_slverr);
    write_expect(mm_pkg::REG_STATUS, 32'h3, mm_pkg::resp_slverr);

    // Random jobs, then one that wraps past 2^31
    for (int r = 0; r < NUM_RAND; r++) begin
      load_operands(1'b0);
      run_job(1'b0);
    end
    load_operands(1'b1);
    run_job(1'b0);

    // Accumulate on top of a previous job
    load_operands(1'b0);
    run_job(1'b0);
    load_operands(1'b0);
    run_job(1'b1);

    // Operand write and second start while busy
    load_operands(1'b0);
    irq_before = irq_count;
    bp_max     = 0;
    write_expect(mm_pkg::REG_CTRL, 32'h1, mm_pkg::resp_okay);
    jobs_started++;
    write_expect(mm_pkg::W_BASE, 32'h0000_1234, mm_pkg::resp_slverr);
    write_expect(mm_pkg::REG_CTRL, 32'h1, mm_pkg::resp_okay);
    bp_max = 3;
    wait_done();
    check_eq("irq pulses of one job", irq_count - irq_before, 1);
    read_expect("W[0][0]", mm_pkg::W_BASE, mm_pkg::axi_data_t'(int'(w_m[0][0])),
                mm_pkg::resp_okay);
    for (int i = 0; i < DIM; i++) begin
      z_ref[i] = ref_matvec(i, 1'b0);
    end
    check_z();

    // Clear while idle, done stays until next start
    write_expect(mm_pkg::REG_CTRL, 32'h4, mm_pkg::resp_okay);
    for (int i = 0; i < DIM; i++) begin
      z_ref[i] = '0;
    end
    check_z();
    read_expect("STATUS", mm_pkg::REG_STATUS, 32'h2, mm_pkg::resp_okay);
    bp_max = 0;
    write_expect(mm_pkg::REG_CTRL, 32'h1, mm_pkg::resp_okay);
    jobs_started++;
    read_expect("STATUS", mm_pkg::REG_STATUS, 32'h1, mm_pkg::resp_okay);
    bp_max = 3;
    wait_done();
    for (int i = 0; i < DIM; i++) begin
      z_ref[i] = ref_matvec(i, 1'b0);
    end
    check_z();

    check_eq("irq pulse count", irq_count, jobs_started);

    if (i_dut.i_ctrl.i_ctrl_asserts.fail_cnt == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      fail_now("A controller assertion failed");
    end
  end

endmodule

`default_nettype wire

/* verification/mm_ctrl_asserts.sv */
// Concurrent checks on the job controller, bound into every mm_ctrl.
// Each failing property raises an error and bumps fail_cnt, which
// the testbench watches every cycle.

`timescale 1ns/10ps
`default_nettype none

module mm_ctrl_asserts #(
  parameter int unsigned DIM = 4
) (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                busy_i,
  input logic                done_i,
  input logic                issue_valid_i,
  input mm_pkg::row_idx_t    issue_row_i,
  input logic                res_valid_i,
  input mm_pkg::ctrl_state_e state_i
);

  int fail_cnt = 0;

  // Rows go out only during a job and only for rows that exist
  a_issue_busy : assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_i |-> busy_i && issue_row_i < DIM)
  else begin
    $error("issue_valid_o outside a job or with a row past DIM-1");
    fail_cnt++;
  end

  a_done_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |=> !done_i)
  else begin
    $error("done_o held for more than one cycle");
    fail_cnt++;
  end

  a_done_after_drain : assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |-> $past(state_i) == mm_pkg::DRAINING)
  else begin
    $error("done_o not preceded by DRAINING");
    fail_cnt++;
  end

  // Results only retire while a job runs
  a_no_result_idle : assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_i |-> state_i != mm_pkg::IDLE)
  else begin
    $error("res_valid_i seen in IDLE");
    fail_cnt++;
  end

endmodule

bind mm_ctrl mm_ctrl_asserts #(
  .DIM (DIM)
) i_ctrl_asserts (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .busy_i        (busy_o),
  .done_i        (done_o),
  .issue_valid_i (issue_valid_o),
  .issue_row_i   (issue_row_o),
  .res_valid_i   (res_valid_i),
  .state_i       (state_q)
);

`default_nettype wire

/* verification/mm_tb_clkgen.sv */
// Clock and reset source for the accelerator testbench.
// Drives a free running clock and holds the active low reset
// for a fixed number of cycles, releasing it just after an edge.

`timescale 1ns/10ps
`default_nettype none

module mm_tb_clkgen #(
  parameter int unsigned PERIOD_NS    = 20,
  parameter int unsigned RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

/* verilog/mm_top.sv */
// Top level of the matrix-vector multiply accelerator.
// Exposes the AXI4-Lite slave and the job interrupt, and connects
// the register decode, controller, engine and result buffer.

`timescale 1ns/10ps
`default_nettype none

module mm_top #(
  parameter int unsigned DIM = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              awvalid_i,
  input  mm_pkg::axi_addr_t awaddr_i,
  input  logic              wvalid_i,
  input  mm_pkg::axi_data_t wdata_i,
  input  logic              bready_i,
  input  logic              arvalid_i,
  input  mm_pkg::axi_addr_t araddr_i,
  input  logic              rready_i,
  output logic              awready_o,
  output logic              wready_o,
  output logic              bvalid_o,
  output logic [1:0]        bresp_o,
  output logic              arready_o,
  output logic              rvalid_o,
  output mm_pkg::axi_data_t rdata_o,
  output logic [1:0]        rresp_o,
  output logic              irq_o
);

  logic                        start;
  logic                        accumulate;
  logic                        clear;
  logic                        busy;
  logic                        done;
  logic                        issue_valid;
  mm_pkg::row_idx_t            issue_row;
  logic                        engine_acc;
  logic                        z_clear;
  logic                        res_valid;
  mm_pkg::row_idx_t            res_row;
  mm_pkg::acc_t                res_data;
  mm_pkg::elem_t [DIM*DIM-1:0] w_flat;
  mm_pkg::elem_t [DIM-1:0]     x_flat;
  mm_pkg::acc_t [DIM-1:0]      z_flat;
  mm_pkg::row_idx_t            z_rd_idx;
  mm_pkg::acc_t                z_rd_data;

  mm_reg_decode #(
    .DIM (DIM)
  ) i_decode (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .awvalid_i    (awvalid_i),
    .awaddr_i     (awaddr_i),
    .wvalid_i     (wvalid_i),
    .wdata_i      (wdata_i),
    .bready_i     (bready_i),
    .arvalid_i    (arvalid_i),
    .araddr_i     (araddr_i),
    .rready_i     (rready_i),
    .busy_i       (busy),
    .done_i       (done),
    .z_rd_data_i  (z_rd_data),
    .awready_o    (awready_o),
    .wready_o     (wready_o),
    .bvalid_o     (bvalid_o),
    .bresp_o      (bresp_o),
    .arready_o    (arready_o),
    .rvalid_o     (rvalid_o),
    .rdata_o      (rdata_o),
    .rresp_o      (rresp_o),
    .start_o      (start),
    .accumulate_o (accumulate),
    .clear_o      (clear),
    .w_flat_o     (w_flat),
    .x_flat_o     (x_flat),
    .z_rd_idx_o   (z_rd_idx)
  );

  mm_ctrl #(
    .DIM (DIM)
  ) i_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (start),
    .accumulate_i  (accumulate),
    .clear_i       (clear),
    .res_valid_i   (res_valid),
    .busy_o        (busy),
    .done_o        (done),
    .irq_o         (irq_o),
    .issue_valid_o (issue_valid),
    .issue_row_o   (issue_row),
    .accumulate_o  (engine_acc),
    .z_clear_o     (z_clear)
  );

  mm_mac_engine #(
    .DIM (DIM)
  ) i_engine (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_valid_i (issue_valid),
    .issue_row_i   (issue_row),
    .accumulate_i  (engine_acc),
    .w_flat_i      (w_flat),
    .x_flat_i      (x_flat),
    .z_flat_i      (z_flat),
    .res_valid_o   (res_valid),
    .res_row_o     (res_row),
    .res_data_o    (res_data)
  );

  mm_z_buffer #(
    .DIM (DIM)
  ) i_zbuf (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (z_clear),
    .wr_valid_i (res_valid),
    .wr_row_i   (res_row),
    .wr_data_i  (res_data),
    .rd_idx_i   (z_rd_idx),
    .z_flat_o   (z_flat),
    .rd_data_o  (z_rd_data)
  );

endmodule

`default_nettype wire

/* verilog/mm_z_buffer.sv */
// Result buffer of the accelerator.
// Holds one accumulator word per row, written by engine results and
// zeroed by a clear. The whole array feeds the engine for accumulate
// mode and one entry is read back by the register decode.

`timescale 1ns/10ps
`default_nettype none

module mm_z_buffer #(
  parameter int unsigned DIM = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   wr_valid_i,
  input  mm_pkg::row_idx_t       wr_row_i,
  input  mm_pkg::acc_t           wr_data_i,
  input  mm_pkg::row_idx_t       rd_idx_i,
  output mm_pkg::acc_t [DIM-1:0] z_flat_o,
  output mm_pkg::acc_t           rd_data_o
);

  mm_pkg::acc_t [DIM-1:0] z_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      z_q <= '0;
    end else if (clear_i) begin
      z_q <= '0;
    end else if (wr_valid_i) begin
      z_q[wr_row_i] <= wr_data_i;
    end
  end

  assign z_flat_o = z_q;

  // Indices past DIM read as zero
  assign rd_data_o = (rd_idx_i < DIM) ? z_q[rd_idx_i] : '0;

endmodule

`default_nettype wire

/* verilog/mm_mac_engine.sv */
// Execute engine of the accelerator.
// Stage 1 multiplies the issued W row by X and captures the previous
// Z entry when accumulating. Stage 2 adds everything up modulo 2^32.
// A new row can enter every cycle, so two rows are in flight.

`timescale 1ns/10ps
`default_nettype none

module mm_mac_engine #(
  parameter int unsigned DIM = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        issue_valid_i,
  input  mm_pkg::row_idx_t            issue_row_i,
  input  logic                        accumulate_i,
  input  mm_pkg::elem_t [DIM*DIM-1:0] w_flat_i,
  input  mm_pkg::elem_t [DIM-1:0]     x_flat_i,
  input  mm_pkg::acc_t [DIM-1:0]      z_flat_i,
  output logic                        res_valid_o,
  output mm_pkg::row_idx_t            res_row_o,
  output mm_pkg::acc_t                res_data_o
);

  mm_pkg::acc_t [DIM-1:0] prod;
  mm_pkg::acc_t [DIM-1:0] prod_q;
  mm_pkg::acc_t           prev_q;
  mm_pkg::row_idx_t       row_q;
  logic                   valid_q;
  mm_pkg::acc_t           sum;

  // Signed 16x16 products of the selected row
  always_comb begin
    for (int j = 0; j < DIM; j++) begin
      prod[j] = $signed(w_flat_i[issue_row_i*DIM + j]) * $signed(x_flat_i[j]);
    end
  end

  always_comb begin
    sum = prev_q;
    for (int j = 0; j < DIM; j++) begin
      sum = sum + prod_q[j];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q     <= 1'b0;
      res_valid_o <= 1'b0;
    end else begin
      valid_q     <= issue_valid_i;
      res_valid_o <= valid_q;
    end
  end

  // Pipeline payload
  always_ff @(posedge clk_i) begin
    prod_q     <= prod;
    prev_q     <= accumulate_i ? z_flat_i[issue_row_i] : '0;
    row_q      <= issue_row_i;
    res_row_o  <= row_q;
    res_data_o <= sum;
  end

endmodule

`default_nettype wire

/* verilog/mm_ctrl.sv */
// Job controller of the accelerator.
// On start it issues one W row per cycle to the engine, counts the
// results that retire, then pulses done and irq for one cycle.
// A clear request reaches the result buffer only while idle.

`timescale 1ns/10ps
`default_nettype none

module mm_ctrl #(
  parameter int unsigned DIM = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             start_i,
  input  logic             accumulate_i,
  input  logic             clear_i,
  input  logic             res_valid_i,
  output logic             busy_o,
  output logic             done_o,
  output logic             irq_o,
  output logic             issue_valid_o,
  output mm_pkg::row_idx_t issue_row_o,
  output logic             accumulate_o,
  output logic             z_clear_o
);

  mm_pkg::ctrl_state_e state_q;
  mm_pkg::ctrl_state_e state_d;
  mm_pkg::row_idx_t    row_q;
  mm_pkg::row_idx_t    ret_q;
  logic                accumulate_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      mm_pkg::IDLE: begin
        if (start_i) begin
          state_d = mm_pkg::COMPUTING;
        end
      end
      mm_pkg::COMPUTING: begin
        if (row_q == mm_pkg::row_idx_t'(DIM - 1)) begin
          state_d = mm_pkg::DRAINING;
        end
      end
      mm_pkg::DRAINING: begin
        // Last result retires in this cycle
        if (res_valid_i && ret_q == mm_pkg::row_idx_t'(DIM - 1)) begin
          state_d = mm_pkg::FINISHED;
        end
      end
      default: begin
        state_d = mm_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= mm_pkg::IDLE;
      row_q        <= '0;
      ret_q        <= '0;
      accumulate_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == mm_pkg::IDLE && start_i) begin
        row_q        <= '0;
        ret_q        <= '0;
        accumulate_q <= accumulate_i;
      end else begin
        if (state_q == mm_pkg::COMPUTING) begin
          row_q <= row_q + 1'b1;
        end
        if (res_valid_i) begin
          ret_q <= ret_q + 1'b1;
        end
      end
    end
  end

  assign busy_o        = (state_q != mm_pkg::IDLE);
  assign done_o        = (state_q == mm_pkg::FINISHED);
  assign irq_o         = (state_q == mm_pkg::FINISHED);
  assign issue_valid_o = (state_q == mm_pkg::COMPUTING);
  assign issue_row_o   = row_q;
  assign accumulate_o  = accumulate_q;
  assign z_clear_o     = clear_i && (state_q == mm_pkg::IDLE);

endmodule

`default_nettype wire

/* verilog/mm_reg_decode.sv */
// AXI4-Lite slave of the accelerator.
// Accepts AW and W together, stores the W matrix and X vector,
// turns CTRL writes into start and clear pulses and serves
// STATUS, operand and Z reads. Errors answer with SLVERR.

`timescale 1ns/10ps
`default_nettype none

module mm_reg_decode #(
  parameter int unsigned DIM = 4
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             awvalid_i,
  input  mm_pkg::axi_addr_t                awaddr_i,
  input  logic                             wvalid_i,
  input  mm_pkg::axi_data_t                wdata_i,
  input  logic                             bready_i,
  input  logic                             arvalid_i,
  input  mm_pkg::axi_addr_t                araddr_i,
  input  logic                             rready_i,
  input  logic                             busy_i,
  input  logic                             done_i,
  input  mm_pkg::acc_t                     z_rd_data_i,
  output logic                             awready_o,
  output logic                             wready_o,
  output logic                             bvalid_o,
  output logic [1:0]                       bresp_o,
  output logic                             arready_o,
  output logic                             rvalid_o,
  output mm_pkg::axi_data_t                rdata_o,
  output logic [1:0]                       rresp_o,
  output logic                             start_o,
  output logic                             accumulate_o,
  output logic                             clear_o,
  output mm_pkg::elem_t [DIM*DIM-1:0]      w_flat_o,
  output mm_pkg::elem_t [DIM-1:0]          x_flat_o,
  output mm_pkg::row_idx_t                 z_rd_idx_o
);

  logic                        wr_hs;
  logic                        rd_hs;
  logic                        idle;
  logic [5:0]                  aw_word;
  logic [5:0]                  ar_word;
  logic                        wr_ctrl;
  logic                        wr_w_en;
  logic                        wr_x_en;
  logic                        wr_err;
  mm_pkg::axi_data_t           rd_data;
  logic [1:0]                  rd_resp;
  logic                        bvalid_q;
  logic [1:0]                  bresp_q;
  logic                        rvalid_q;
  mm_pkg::axi_data_t           rdata_q;
  logic [1:0]                  rresp_q;
  logic                        start_q;
  logic                        accumulate_q;
  logic                        clear_q;
  logic                        done_q;
  mm_pkg::elem_t [DIM*DIM-1:0] w_q;
  mm_pkg::elem_t [DIM-1:0]     x_q;

  // A start still on its way to the controller counts as busy
  assign idle    = !busy_i && !start_q;
  assign wr_hs   = awvalid_i && wvalid_i && !bvalid_q;
  assign rd_hs   = arvalid_i && !rvalid_q;
  assign aw_word = awaddr_i[7:2];
  assign ar_word = araddr_i[7:2];

  always_comb begin
    wr_ctrl = 1'b0;
    wr_w_en = 1'b0;
    wr_x_en = 1'b0;
    wr_err  = 1'b1;
    if (awaddr_i == mm_pkg::REG_CTRL) begin
      wr_ctrl = 1'b1;
      wr_err  = 1'b0;
    end else if (awaddr_i[1:0] == 2'b00 && awaddr_i[11:8] == mm_pkg::W_BASE[11:8] &&
                 aw_word < DIM*DIM) begin
      wr_w_en = idle;
      wr_err  = !idle;
    end else if (awaddr_i[1:0] == 2'b00 && awaddr_i[11:8] == mm_pkg::X_BASE[11:8] &&
                 aw_word < DIM) begin
      wr_x_en = idle;
      wr_err  = !idle;
    end
  end

  always_comb begin
    rd_data = '0;
    rd_resp = mm_pkg::resp_slverr;
    if (araddr_i == mm_pkg::REG_CTRL) begin
      rd_resp = mm_pkg::resp_okay;
    end else if (araddr_i == mm_pkg::REG_STATUS) begin
      rd_data = {30'b0, done_q, busy_i};
      rd_resp = mm_pkg::resp_okay;
    end else if (araddr_i[1:0] == 2'b00) begin
      if (araddr_i[11:8] == mm_pkg::W_BASE[11:8] && ar_word < DIM*DIM) begin
        rd_data = {{16{w_q[ar_word][15]}}, w_q[ar_word]};
        rd_resp = mm_pkg::resp_okay;
      end else if (araddr_i[11:8] == mm_pkg::X_BASE[11:8] && ar_word < DIM) begin
        rd_data = {{16{x_q[ar_word][15]}}, x_q[ar_word]};
        rd_resp = mm_pkg::resp_okay;
      end else if (araddr_i[11:8] == mm_pkg::Z_BASE[11:8] && ar_word < DIM) begin
        rd_data = z_rd_data_i;
        rd_resp = mm_pkg::resp_okay;
      end
    end
  end

  // Write channel, operand storage and CTRL pulses
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bvalid_q     <= 1'b0;
      bresp_q      <= mm_pkg::resp_okay;
      start_q      <= 1'b0;
      clear_q      <= 1'b0;
      accumulate_q <= 1'b0;
      w_q          <= '0;
      x_q          <= '0;
    end else begin
      start_q <= 1'b0;
      clear_q <= 1'b0;
      if (wr_hs) begin
        bvalid_q <= 1'b1;
        bresp_q  <= wr_err ? mm_pkg::resp_slverr : mm_pkg::resp_okay;
        if (wr_ctrl && idle) begin
          start_q <= wdata_i[0];
          clear_q <= wdata_i[2];
          if (wdata_i[0]) begin
            accumulate_q <= wdata_i[1];
          end
        end
        if (wr_w_en) begin
          w_q[aw_word] <= wdata_i[15:0];
        end
        if (wr_x_en) begin
          x_q[aw_word] <= wdata_i[15:0];
        end
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  // Read channel and sticky done flag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
      rresp_q  <= mm_pkg::resp_okay;
      done_q   <= 1'b0;
    end else begin
      if (rd_hs) begin
        rvalid_q <= 1'b1;
        rdata_q  <= rd_data;
        rresp_q  <= rd_resp;
      end else if (rready_i) begin
        rvalid_q <= 1'b0;
      end
      if (start_q) begin
        done_q <= 1'b0;
      end else if (done_i) begin
        done_q <= 1'b1;
      end
    end
  end

  assign awready_o    = wr_hs;
  assign wready_o     = wr_hs;
  assign bvalid_o     = bvalid_q;
  assign bresp_o      = bresp_q;
  assign arready_o    = !rvalid_q;
  assign rvalid_o     = rvalid_q;
  assign rdata_o      = rdata_q;
  assign rresp_o      = rresp_q;
  assign start_o      = start_q;
  assign accumulate_o = accumulate_q;
  assign clear_o      = clear_q;
  assign w_flat_o     = w_q;
  assign x_flat_o     = x_q;
  assign z_rd_idx_o   = araddr_i[4:2];

endmodule

`default_nettype wire

/* verilog/mm_pkg.sv */
// Shared definitions for the matrix-vector multiply accelerator.
// Holds the operand and result types, the AXI4-Lite word types,
// the register map and the controller state encoding.
// Every RTL block refers to these by scoped name.

`default_nettype none

package mm_pkg;

  // Operand and result widths
  typedef logic signed [15:0] elem_t;
  typedef logic        [31:0] acc_t;

  // AXI4-Lite words
  typedef logic [11:0] axi_addr_t;
  typedef logic [31:0] axi_data_t;

  // Row index, wide enough for DIM up to 8
  typedef logic [2:0] row_idx_t;

  // Register map, byte addresses
  localparam axi_addr_t REG_CTRL   = 12'h000;
  localparam axi_addr_t REG_STATUS = 12'h004;
  localparam axi_addr_t W_BASE     = 12'h100;
  localparam axi_addr_t X_BASE     = 12'h200;
  localparam axi_addr_t Z_BASE     = 12'h300;

  // AXI response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  typedef enum logic [1:0] {IDLE, COMPUTING, DRAINING, FINISHED} ctrl_state_e;

endpackage

`default_nettype wire
